//--- bench/lsu_vectors.txt
# name start_bank block_factor cyclic_factor stride addr_offset len backpressure
# all values decimal, len a multiple of eight, backpressure 1 randomizes ss_out_ready
basic        0  1  4  1    0  32 0
blocked      1  4  2  1   16  64 0
strided      0  2  3  5  100  48 1
groups       2  2  8  1    0  64 0
groups_bp    2  3  8  2   40  96 1
wide_block   3 16  1  1  512 128 1
single_bank  0  8  1  3    7  40 0
cyc_wrap     1  1  6  1  200  48 1
high_group  20  2  5  4 3000  80 1

//--- tb.f
hdl/lsu_pkg.sv
hdl/lsu_fifo.sv
hdl/lsu_addr_gen.sv
hdl/lsu_store_path.sv
hdl/lsu_load_path.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
bench/tb_bank_model.sv
bench/tb_lsu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_lsu
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
  import lsu_pkg::*;
;

  localparam int rd_lat = 3;

  logic                clk;
  logic                arst_n;
  logic                start;
  lsu_cfg_t            cfg;
  logic                done;
  beat_t               ss_in_data;
  logic                ss_in_valid;
  logic                ss_in_ready;
  beat_t               ss_out_data;
  logic                ss_out_valid;
  logic                ss_out_ready;
  bank_req_t           bank_req;
  word_t [n_banks-1:0] bank_q;
  int                  write_count;

  logic [127:0] names [32];
  int sb [32];
  int bf [32];
  int cf [32];
  int st [32];
  int off [32];
  int len [32];
  int bp [32];
  int n_lines;
  int errors;
  int passed;
  int failed;
  int limit;
  int seed;
  word_t refmem [int];
  word_t wdata [$];

  lsu_top #(
    .rd_lat     (rd_lat),
    .beat_depth (2),
    .word_depth (8)
  ) dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .cfg          (cfg),
    .done         (done),
    .ss_in_data   (ss_in_data),
    .ss_in_valid  (ss_in_valid),
    .ss_in_ready  (ss_in_ready),
    .ss_out_data  (ss_out_data),
    .ss_out_valid (ss_out_valid),
    .ss_out_ready (ss_out_ready),
    .bank_req     (bank_req),
    .bank_q       (bank_q)
  );

  tb_bank_model #(
    .rd_lat (rd_lat)
  ) u_banks (
    .clk         (clk),
    .bank_req    (bank_req),
    .bank_q      (bank_q),
    .write_count (write_count)
  );

  always #4 clk = ~clk;

  // layout rule, returns {group, bank, addr}
  function automatic int layout_key(input int t, input int k);
    int j;
    int c;
    int r;
    int g;
    int a;
    j = k % bf[t];
    c = (k / bf[t]) % cf[t];
    r = k / (bf[t] * cf[t]);
    g = sb[t] + c;
    a = (off[t] + r * bf[t] + j * st[t]) % 4096;
    layout_key = ((g / 4) << 14) | ((g % 4) << 12) | a;
  endfunction

  task automatic report_mismatch(input string tname, input string field,
                                 input logic [511:0] exp_v, input logic [511:0] act_v);
    $display("MISMATCH %s %s expected %0h actual %0h", tname, field, exp_v, act_v);
    errors++;
  endtask

  task automatic check_idle(input string tname, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      if (ss_in_ready || bank_req.ce != '0 || done || ss_out_valid) begin
        $display("ERROR %s: unit not quiet in idle (ready, ce, done or valid high)", tname);
        errors++;
      end
    end
  endtask

  task automatic pulse_start(input int t, input lsu_op_e op);
    @(posedge clk);
    #1;
    cfg.op            = op;
    cfg.start_bank    = 8'(sb[t]);
    cfg.block_factor  = 16'(bf[t]);
    cfg.cyclic_factor = 16'(cf[t]);
    cfg.stride        = addr_w'(st[t]);
    cfg.addr_offset   = addr_w'(off[t]);
    cfg.len           = 16'(len[t]);
    start             = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic run_store(input int t, input string tname);
    int    beat_idx;
    int    wr_idx;
    int    key;
    int    wc0;
    int    nb;
    beat_t b;
    beat_idx = 0;
    wr_idx   = 0;
    wc0      = write_count;
    nb       = len[t] / 8;
    wdata.delete();
    for (int k = 0; k < len[t]; k++) begin
      wdata.push_back({32'($random(seed)), 32'($random(seed))});
    end
    pulse_start(t, op_store);
    forever begin
      if (beat_idx < nb) begin
        for (int i = 0; i < 8; i++) begin
          b[i*word_w +: word_w] = wdata[beat_idx*8 + i];
        end
        ss_in_data  = b;
        ss_in_valid = 1'b1;
      end else begin
        ss_in_valid = 1'b0;
      end
      @(posedge clk);
      if (ss_in_valid && ss_in_ready) begin
        beat_idx++;
      end
      if (bank_req.ce != '0) begin
        if (wr_idx >= len[t]) begin
          $display("ERROR %s: write after the last element", tname);
          errors++;
        end else begin
          key = layout_key(t, wr_idx);
          if (!bank_req.we) begin
            report_mismatch(tname, "we", 1, 0);
          end
          if (bank_req.ce != 4'(1 << ((key >> 12) & 3))) begin
            report_mismatch(tname, "ce", 1 << ((key >> 12) & 3), bank_req.ce);
          end
          if (int'(bank_req.group) != (key >> 14)) begin
            report_mismatch(tname, "group", key >> 14, bank_req.group);
          end
          if (int'(bank_req.addr) != (key & 4095)) begin
            report_mismatch(tname, "addr", key & 4095, bank_req.addr);
          end
          if (bank_req.d != wdata[wr_idx]) begin
            report_mismatch(tname, "data", wdata[wr_idx], bank_req.d);
          end
          refmem[key] = wdata[wr_idx];
        end
        wr_idx++;
      end
      if (done) begin
        break;
      end
      #1;
    end
    if (wr_idx != len[t]) begin
      report_mismatch(tname, "write count", len[t], wr_idx);
    end
    if (write_count - wc0 != len[t]) begin
      report_mismatch(tname, "model writes", len[t], write_count - wc0);
    end
    #1;
    ss_in_valid = 1'b0;
  endtask

  task automatic run_load(input int t, input string tname);
    int         beat_idx;
    int         nb;
    logic       prev_valid;
    logic       prev_ready;
    beat_t      prev_data;
    beat_t      exp_beat;
    logic [31:0] r;
    beat_idx   = 0;
    nb         = len[t] / 8;
    prev_valid = 1'b0;
    prev_ready = 1'b1;
    prev_data  = '0;
    pulse_start(t, op_load);
    forever begin
      @(posedge clk);
      if (ss_out_valid && prev_valid && !prev_ready && ss_out_data != prev_data) begin
        report_mismatch(tname, "held beat", prev_data, ss_out_data);
      end
      if (prev_valid && !prev_ready && !ss_out_valid) begin
        $display("ERROR %s: ss_out_valid dropped before the beat moved", tname);
        errors++;
      end
      if (bank_req.ce != '0 && bank_req.we) begin
        $display("ERROR %s: write issued during a load", tname);
        errors++;
      end
      if (ss_in_ready) begin
        $display("ERROR %s: input stream ready during a load", tname);
        errors++;
      end
      if (ss_out_valid && ss_out_ready) begin
        if (beat_idx >= nb) begin
          $display("ERROR %s: extra beat on the output stream", tname);
          errors++;
        end else begin
          for (int i = 0; i < 8; i++) begin
            exp_beat[i*word_w +: word_w] = refmem[layout_key(t, beat_idx*8 + i)];
          end
          if (ss_out_data != exp_beat) begin
            report_mismatch(tname, $sformatf("beat %0d", beat_idx), exp_beat, ss_out_data);
          end
        end
        beat_idx++;
      end
      prev_valid = ss_out_valid;
      prev_ready = ss_out_ready;
      prev_data  = ss_out_data;
      if (done) begin
        break;
      end
      #1;
      r = $random(seed);
      ss_out_ready = (bp[t] != 0) ? r[0] : 1'b1;
    end
    if (beat_idx != nb) begin
      report_mismatch(tname, "beat count", nb, beat_idx);
    end
    #1;
    ss_out_ready = 1'b1;
  endtask

  task automatic read_vectors();
    int    fd;
    int    n;
    string line;
    fd = $fopen("bench/lsu_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR could not open bench/lsu_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_lines < 32) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 2 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d", names[n_lines], sb[n_lines],
                      bf[n_lines], cf[n_lines], st[n_lines], off[n_lines],
                      len[n_lines], bp[n_lines]);
          if (n == 8) begin
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // watchdog
  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("ERROR watchdog expired after %0d cycles, DUT stopped responding", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int    e0;
    string tname;
    clk          = 1'b0;
    arst_n       = 1'b0;
    start        = 1'b0;
    cfg          = '0;
    ss_in_data   = '0;
    ss_in_valid  = 1'b0;
    ss_out_ready = 1'b1;
    seed         = 32'h3d81;
    errors       = 0;
    passed       = 0;
    failed       = 0;
    n_lines      = 0;
    limit        = 0;
    read_vectors();
    for (int t = 0; t < n_lines; t++) begin
      limit += 40 * len[t];
    end
    limit += 200;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_idle("reset", 3);
    for (int t = 0; t < n_lines; t++) begin
      for (int ph = 0; ph < 2; ph++) begin
        e0    = errors;
        tname = $sformatf("%0s_%0s", names[t], (ph == 0) ? "store" : "load");
        if (ph == 0) begin
          run_store(t, tname);
        end else begin
          run_load(t, tname);
        end
        check_idle(tname, 4);
        if (errors == e0) begin
          $display("PASS %s", tname);
          passed++;
        end else begin
          $display("FAIL %s with %0d errors", tname, errors - e0);
          failed++;
        end
      end
    end
    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0 && n_lines > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_bank_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bank_model
  import lsu_pkg::*;
#(
  parameter int rd_lat = 3
) (
  input  logic                clk,
  input  bank_req_t           bank_req,
  output word_t [n_banks-1:0] bank_q,
  output int                  write_count
);

  // sparse storage keyed by {group, bank, addr}
  word_t mem [int];
  word_t [n_banks-1:0] q_pipe [rd_lat];

  function automatic int mem_key(input int b);
    mem_key = (int'(bank_req.group) << 14) | (b << 12) | int'(bank_req.addr);
  endfunction

  initial begin
    write_count = 0;
  end

  always @(posedge clk) begin
    for (int b = 0; b < n_banks; b++) begin
      if (bank_req.ce[b] && bank_req.we) begin
        mem[mem_key(b)] = bank_req.d;
        write_count = write_count + 1;
      end
    end
  end

  // data reaches bank_q rd_lat cycles after the request is on the port
  // unwritten locations read back a pattern made from their own key
  always @(posedge clk) begin
    for (int b = 0; b < n_banks; b++) begin
      if (bank_req.ce[b] && !bank_req.we) begin
        q_pipe[0][b] <= mem.exists(mem_key(b)) ? mem[mem_key(b)]
                                               : {~32'(mem_key(b)), 32'(mem_key(b))};
      end
    end
    for (int i = 1; i < rd_lat; i++) begin
      q_pipe[i] <= q_pipe[i-1];
    end
  end

  assign bank_q = q_pipe[rd_lat-1];

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
#(
  parameter int rd_lat     = 3,
  parameter int beat_depth = 2,
  parameter int word_depth = 8
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                start,
  input  lsu_cfg_t            cfg,
  output logic                done,
  input  beat_t               ss_in_data,
  input  logic                ss_in_valid,
  output logic                ss_in_ready,
  output beat_t               ss_out_data,
  output logic                ss_out_valid,
  input  logic                ss_out_ready,
  output bank_req_t           bank_req,
  input  word_t [n_banks-1:0] bank_q
);

  logic              running;
  word_t             word;
  logic              word_avail;
  logic              take;
  logic              rd_credit;
  logic              rd_issue;
  logic [1:0]        rd_bank;
  logic              beat_sent;
  logic              step;
  logic              load;
  logic              last;
  logic [1:0]        bank;
  logic [grp_w-1:0]  group;
  logic [addr_w-1:0] addr;

  lsu_ctrl u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .cfg        (cfg),
    .done       (done),
    .running    (running),
    .word       (word),
    .word_avail (word_avail),
    .take       (take),
    .rd_credit  (rd_credit),
    .rd_issue   (rd_issue),
    .rd_bank    (rd_bank),
    .beat_sent  (beat_sent),
    .step       (step),
    .load       (load),
    .last       (last),
    .bank       (bank),
    .group      (group),
    .addr       (addr),
    .bank_req   (bank_req)
  );

  lsu_addr_gen u_addr_gen (
    .clk    (clk),
    .arst_n (arst_n),
    .cfg    (cfg),
    .load   (load),
    .step   (step),
    .bank   (bank),
    .group  (group),
    .addr   (addr),
    .last   (last)
  );

  lsu_store_path #(
    .beat_depth (beat_depth)
  ) u_store_path (
    .clk         (clk),
    .arst_n      (arst_n),
    .running     (running),
    .ss_in_data  (ss_in_data),
    .ss_in_valid (ss_in_valid),
    .ss_in_ready (ss_in_ready),
    .word        (word),
    .word_avail  (word_avail),
    .take        (take)
  );

  lsu_load_path #(
    .rd_lat     (rd_lat),
    .word_depth (word_depth)
  ) u_load_path (
    .clk          (clk),
    .arst_n       (arst_n),
    .rd_issue     (rd_issue),
    .rd_bank      (rd_bank),
    .bank_q       (bank_q),
    .rd_credit    (rd_credit),
    .ss_out_data  (ss_out_data),
    .ss_out_valid (ss_out_valid),
    .ss_out_ready (ss_out_ready),
    .beat_sent    (beat_sent)
  );

endmodule

`default_nettype wire

//--- hdl/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              start,
  input  lsu_cfg_t          cfg,
  output logic              done,
  output logic              running,
  input  word_t             word,
  input  logic              word_avail,
  output logic              take,
  input  logic              rd_credit,
  output logic              rd_issue,
  output logic [1:0]        rd_bank,
  input  logic              beat_sent,
  output logic              step,
  output logic              load,
  input  logic              last,
  input  logic [1:0]        bank,
  input  logic [grp_w-1:0]  group,
  input  logic [addr_w-1:0] addr,
  output bank_req_t         bank_req
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } state_e;

  state_e             state;
  lsu_op_e            op_q;
  logic [12:0]        beat_total;
  logic [12:0]        beat_cnt;
  logic               issued_all;
  logic               is_store;
  logic               is_load;
  logic               last_beat;
  logic               finish;

  logic [n_banks-1:0] req_ce;
  logic               req_we;
  logic [grp_w-1:0]   req_group;
  logic [addr_w-1:0]  req_addr;
  word_t              req_d;

  assign load      = (state == st_idle) & start;
  assign is_store  = (state == st_run) & (op_q == op_store);
  assign is_load   = (state == st_run) & (op_q == op_load);
  assign running   = is_store;
  assign take      = is_store & word_avail;
  assign rd_issue  = is_load & rd_credit & ~issued_all;
  assign rd_bank   = bank;
  assign step      = take | rd_issue;
  assign last_beat = (beat_cnt == beat_total - 13'd1);
  assign finish    = (take & last) | (is_load & beat_sent & last_beat);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      op_q       <= op_store;
      issued_all <= 1'b0;
      beat_cnt   <= '0;
      done       <= 1'b0;
    end else begin
      // store done trails the last write, load done follows the last beat
      done <= ((state == st_done) & (op_q == op_store)) | (is_load & beat_sent & last_beat);
      case (state)
        st_idle: begin
          if (start) begin
            state      <= st_run;
            op_q       <= cfg.op;
            issued_all <= 1'b0;
            beat_cnt   <= '0;
          end
        end
        st_run: begin
          if (rd_issue & last) begin
            issued_all <= 1'b1;
          end
          if (beat_sent) begin
            beat_cnt <= beat_cnt + 13'd1;
          end
          if (finish) begin
            state <= st_done;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      beat_total <= cfg.len[15:3];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_ce <= '0;
      req_we <= 1'b0;
    end else begin
      req_ce <= step ? ({{(n_banks-1){1'b0}}, 1'b1} << bank) : '0;
      req_we <= take;
    end
  end

  always_ff @(posedge clk) begin
    req_group <= group;
    req_addr  <= addr;
    req_d     <= word;
  end

  assign bank_req = '{ce: req_ce, we: req_we, group: req_group, addr: req_addr, d: req_d};

endmodule

`default_nettype wire

//--- hdl/lsu_load_path.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_path
  import lsu_pkg::*;
#(
  parameter int rd_lat     = 3,
  parameter int word_depth = 8
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    rd_issue,
  input  logic [1:0]              rd_bank,
  input  word_t [n_banks-1:0]     bank_q,
  output logic                    rd_credit,
  output beat_t                   ss_out_data,
  output logic                    ss_out_valid,
  input  logic                    ss_out_ready,
  output logic                    beat_sent
);

  localparam int cnt_w = $clog2(word_depth+1);

  // stage 0 lines up with the request on the bank port
  logic [rd_lat:0]      vld_pipe;
  logic [rd_lat:0][1:0] bank_pipe;
  logic                 rd_back;
  word_t                rd_word;

  logic [cnt_w-1:0]     outstanding;
  logic [cnt_w-1:0]     word_count;
  logic                 wf_empty;
  logic                 wf_pop;
  word_t                wf_data;

  beat_t                pk_data;
  logic [2:0]           pk_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[rd_lat-1:0], rd_issue};
    end
  end

  always_ff @(posedge clk) begin
    bank_pipe <= {bank_pipe[rd_lat-1:0], rd_bank};
  end

  assign rd_back = vld_pipe[rd_lat];
  assign rd_word = bank_q[bank_pipe[rd_lat]];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= '0;
    end else begin
      case ({rd_issue, rd_back})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // reads in flight must always find room in the word FIFO
  assign rd_credit = ({1'b0, outstanding} + {1'b0, word_count}) < (cnt_w+1)'(word_depth);

  lsu_fifo #(
    .payload_t (word_t),
    .depth     (word_depth)
  ) u_word_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (rd_back),
    .push_data (rd_word),
    .full      (),
    .pop       (wf_pop),
    .pop_data  (wf_data),
    .empty     (wf_empty),
    .count     (word_count)
  );

  // packer stalls while a finished beat waits on the stream
  assign wf_pop = ~wf_empty & ~ss_out_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pk_cnt       <= '0;
      ss_out_valid <= 1'b0;
    end else begin
      if (wf_pop) begin
        pk_cnt <= pk_cnt + 3'd1;
        if (pk_cnt == 3'd7) begin
          ss_out_valid <= 1'b1;
        end
      end else if (beat_sent) begin
        ss_out_valid <= 1'b0;
      end
    end
  end

  // words shift in from the top so word 0 ends up low
  always_ff @(posedge clk) begin
    if (wf_pop) begin
      pk_data <= {wf_data, pk_data[words_per_beat*word_w-1:word_w]};
    end
  end

  assign ss_out_data = pk_data;
  assign beat_sent   = ss_out_valid & ss_out_ready;

endmodule

`default_nettype wire

//--- hdl/lsu_store_path.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_path
  import lsu_pkg::*;
#(
  parameter int beat_depth = 2
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  running,
  input  beat_t ss_in_data,
  input  logic  ss_in_valid,
  output logic  ss_in_ready,
  output word_t word,
  output logic  word_avail,
  input  logic  take
);

  logic       fifo_full;
  logic       fifo_empty;
  logic       fifo_pop;
  beat_t      fifo_data;
  beat_t      shreg;
  logic       sh_valid;
  logic [2:0] wcnt;

  assign ss_in_ready = running & ~fifo_full;

  lsu_fifo #(
    .payload_t (beat_t),
    .depth     (beat_depth)
  ) u_beat_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (ss_in_valid & ss_in_ready),
    .push_data (ss_in_data),
    .full      (fifo_full),
    .pop       (fifo_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .count     ()
  );

  // refill when empty or as the eighth word leaves
  assign fifo_pop = (~sh_valid | (take & (wcnt == 3'd7))) & ~fifo_empty;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sh_valid <= 1'b0;
      wcnt     <= '0;
    end else if (fifo_pop) begin
      sh_valid <= 1'b1;
      wcnt     <= '0;
    end else if (take) begin
      wcnt <= wcnt + 3'd1;
      if (wcnt == 3'd7) begin
        sh_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      shreg <= fifo_data;
    end else if (take) begin
      shreg <= shreg >> word_w;
    end
  end

  assign word       = shreg[word_w-1:0];
  assign word_avail = sh_valid;

endmodule

`default_nettype wire

//--- hdl/lsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  lsu_cfg_t          cfg,
  input  logic              load,
  input  logic              step,
  output logic [1:0]        bank,
  output logic [grp_w-1:0]  group,
  output logic [addr_w-1:0] addr,
  output logic              last
);

  logic [15:0]       bf_q;
  logic [15:0]       cf_q;
  logic [15:0]       len_q;
  logic [addr_w-1:0] stride_q;
  logic [addr_w-1:0] offset_q;
  logic [grp_w+1:0]  start_q;

  logic [15:0]       blk_cnt;
  logic [15:0]       cyc_cnt;
  logic [15:0]       elem_cnt;
  logic [addr_w-1:0] row_base;
  logic [addr_w-1:0] addr_q;
  // global bank number, bank in the low two bits
  logic [grp_w+1:0]  gbank;

  logic              blk_wrap;
  logic              cyc_wrap;
  logic [addr_w-1:0] next_row;

  assign blk_wrap = (blk_cnt == bf_q - 16'd1);
  assign cyc_wrap = (cyc_cnt == cf_q - 16'd1);
  assign next_row = row_base + bf_q[addr_w-1:0];

  always_ff @(posedge clk) begin
    if (load) begin
      bf_q     <= cfg.block_factor;
      cf_q     <= cfg.cyclic_factor;
      len_q    <= cfg.len;
      stride_q <= cfg.stride;
      offset_q <= cfg.addr_offset;
      start_q  <= cfg.start_bank[grp_w+1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      blk_cnt  <= '0;
      cyc_cnt  <= '0;
      elem_cnt <= '0;
      row_base <= '0;
      addr_q   <= '0;
      gbank    <= '0;
    end else if (load) begin
      blk_cnt  <= '0;
      cyc_cnt  <= '0;
      elem_cnt <= '0;
      row_base <= '0;
      addr_q   <= cfg.addr_offset;
      gbank    <= cfg.start_bank[grp_w+1:0];
    end else if (step) begin
      elem_cnt <= elem_cnt + 16'd1;
      if (blk_wrap) begin
        blk_cnt <= '0;
        if (cyc_wrap) begin
          // next row of blocks, back to the first bank
          cyc_cnt  <= '0;
          gbank    <= start_q;
          row_base <= next_row;
          addr_q   <= offset_q + next_row;
        end else begin
          cyc_cnt <= cyc_cnt + 16'd1;
          gbank   <= gbank + 1'b1;
          addr_q  <= offset_q + row_base;
        end
      end else begin
        blk_cnt <= blk_cnt + 16'd1;
        addr_q  <= addr_q + stride_q;
      end
    end
  end

  assign bank  = gbank[1:0];
  assign group = gbank[grp_w+1:2];
  assign addr  = addr_q;
  assign last  = (elem_cnt == len_q - 16'd1);

endmodule

`default_nettype wire

//--- hdl/lsu_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       push,
  input  payload_t                   push_data,
  output logic                       full,
  input  logic                       pop,
  output payload_t                   pop_data,
  output logic                       empty,
  output logic [$clog2(depth+1)-1:0] count
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth+1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    next_ptr = (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full     = (count == cnt_w'(depth));
  assign empty    = (count == '0);
  assign do_push  = push & ~full;
  assign do_pop   = pop & ~empty;
  // head word is visible before the pop
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int n_banks        = 4;
  localparam int words_per_beat = 8;
  localparam int word_w         = 64;
  localparam int addr_w         = 12;
  localparam int grp_w          = 5;

  typedef logic [word_w-1:0] word_t;

  // word 0 sits in the low bits
  typedef logic [words_per_beat*word_w-1:0] beat_t;

  typedef enum logic {
    op_store = 1'b0,
    op_load  = 1'b1
  } lsu_op_e;

  // operation settings, captured on start
  typedef struct packed {
    lsu_op_e           op;
    logic [7:0]        start_bank;
    logic [15:0]       block_factor;
    logic [15:0]       cyclic_factor;
    logic [addr_w-1:0] stride;
    logic [addr_w-1:0] addr_offset;
    logic [15:0]       len;
  } lsu_cfg_t;

  // one access on the shared bank port
  typedef struct packed {
    logic [n_banks-1:0] ce;
    logic               we;
    logic [grp_w-1:0]   group;
    logic [addr_w-1:0]  addr;
    word_t              d;
  } bank_req_t;

endpackage

`default_nettype wire
